/* common/tstamp_pkg.sv */
package tstamp_pkg;

  // channel and data widths
  localparam int N_CH             = 4;
  localparam int SAMPLE_W         = 12;
  localparam int TIME_STAMP_WIDTH = 16;
  localparam int CH_W             = 2;
  localparam int APB_AW           = 8;

  // clock cycles per timestamp tick
  localparam int CLK_DIVIDE = 5;
  localparam int DIV_W      = $clog2(CLK_DIVIDE);

  typedef logic [SAMPLE_W-1:0]         sample_t;
  typedef logic [TIME_STAMP_WIDTH-1:0] tstamp_t;
  typedef logic [CH_W-1:0]             ch_idx_t;
  typedef logic [APB_AW-1:0]           apb_addr_t;
  typedef logic [31:0]                 apb_data_t;

  // register map
  localparam apb_addr_t ADDR_CTRL   = 8'h00;
  localparam apb_addr_t ADDR_STATUS = 8'h04;
  localparam apb_addr_t ADDR_HYST   = 8'h08;
  localparam apb_addr_t ADDR_THRESH = 8'h10;
  localparam apb_addr_t ADDR_OFFSET = 8'h20;

  // overflow flags start at this STATUS bit
  localparam int OVF_LSB = 4;

  // execution state, same codes as the ADC front end
  typedef enum logic [1:0] {
    INIT  = 2'b00,
    ARMED = 2'b01,
    TRG   = 2'b11
  } exec_state_t;

  // one sample per channel
  typedef struct packed {
    sample_t [N_CH-1:0] s;
  } frame_t;

  // output event record
  typedef struct packed {
    ch_idx_t ch;
    sample_t sample;
    tstamp_t ts;
  } event_t;

  // per-channel configuration
  typedef struct packed {
    sample_t thresh;
    sample_t offset;
  } ch_cfg_t;

endpackage

/* logic/time_counter.sv */
`timescale 1ns/1ns

module time_counter (
  input  logic                    AXIS_ACLK,
  input  logic                    AXIS_ARESETN,
  input  tstamp_pkg::exec_state_t exec_state,
  output tstamp_pkg::tstamp_t     current_time
);

  import tstamp_pkg::*;

  logic [DIV_W-1:0] presc;
  logic             tick;

  // last prescaler count gives one tick
  assign tick = (presc == DIV_W'(CLK_DIVIDE - 1));

  // both counters held at zero in INIT so timing restarts on arming
  always_ff @(posedge AXIS_ACLK) begin
    if (!AXIS_ARESETN || exec_state == INIT) begin
      presc        <= '0;
      current_time <= '0;
    end else begin
      if (tick) begin
        presc <= '0;
      end else begin
        presc <= presc + 1'b1;
      end
      // wraps at full width
      current_time <= current_time + tstamp_t'(tick);
    end
  end

endmodule

/* logic/apb_regs.sv */
`timescale 1ns/1ns

module apb_regs (
  input  logic                                 AXIS_ACLK,
  input  logic                                 AXIS_ARESETN,
  input  logic                                 psel,
  input  logic                                 penable,
  input  logic                                 pwrite,
  input  tstamp_pkg::apb_addr_t                paddr,
  input  tstamp_pkg::apb_data_t                pwdata,
  output tstamp_pkg::apb_data_t                prdata,
  output logic                                 pready,
  output logic                                 pslverr,
  input  logic                                 event_taken,
  input  logic [tstamp_pkg::N_CH-1:0]          overflow,
  output tstamp_pkg::exec_state_t              exec_state,
  output tstamp_pkg::ch_cfg_t [tstamp_pkg::N_CH-1:0] ch_cfg,
  output tstamp_pkg::sample_t                  hyst
);

  import tstamp_pkg::*;

  logic            run;
  logic [N_CH-1:0] ovf_flags;
  logic            access;
  logic            wr;
  logic            sel_ctrl;
  logic            sel_status;
  logic            sel_hyst;
  logic            sel_thr;
  logic            sel_off;
  logic            addr_hit;
  ch_idx_t         idx;

  assign access = psel && penable;
  assign wr     = access && pwrite;

  // channel registers sit at a 4-byte stride inside their block
  assign idx        = paddr[CH_W+1:2];
  assign sel_ctrl   = (paddr == ADDR_CTRL);
  assign sel_status = (paddr == ADDR_STATUS);
  assign sel_hyst   = (paddr == ADDR_HYST);
  assign sel_thr    = (paddr[APB_AW-1:4] == ADDR_THRESH[APB_AW-1:4]) && (paddr[1:0] == 2'b00);
  assign sel_off    = (paddr[APB_AW-1:4] == ADDR_OFFSET[APB_AW-1:4]) && (paddr[1:0] == 2'b00);
  assign addr_hit   = sel_ctrl || sel_status || sel_hyst || sel_thr || sel_off;

  // zero wait states
  assign pready  = 1'b1;
  assign pslverr = access && !addr_hit;

  // configuration registers
  always_ff @(posedge AXIS_ACLK) begin
    if (!AXIS_ARESETN) begin
      run    <= 1'b0;
      hyst   <= '0;
      ch_cfg <= '0;
    end else if (wr) begin
      if (sel_ctrl) run <= pwdata[0];
      if (sel_hyst) hyst <= pwdata[SAMPLE_W-1:0];
      if (sel_thr)  ch_cfg[idx].thresh <= pwdata[SAMPLE_W-1:0];
      if (sel_off)  ch_cfg[idx].offset <= pwdata[SAMPLE_W-1:0];
    end
  end

  // sticky overflow, a new pulse wins over a clear in the same cycle
  always_ff @(posedge AXIS_ACLK) begin
    if (!AXIS_ARESETN) begin
      ovf_flags <= '0;
    end else if (wr && sel_status) begin
      ovf_flags <= (ovf_flags & ~pwdata[OVF_LSB +: N_CH]) | overflow;
    end else begin
      ovf_flags <= ovf_flags | overflow;
    end
  end

  // execution state machine
  always_ff @(posedge AXIS_ACLK) begin
    if (!AXIS_ARESETN) begin
      exec_state <= INIT;
    end else if (wr && sel_ctrl && !pwdata[0]) begin
      exec_state <= INIT;
    end else begin
      case (exec_state)
        INIT:    if (wr && sel_ctrl && pwdata[0]) exec_state <= ARMED;
        ARMED:   if (event_taken) exec_state <= TRG;
        TRG:     exec_state <= TRG;
        default: exec_state <= INIT;
      endcase
    end
  end

  // read mux
  always_comb begin
    prdata = '0;
    if (sel_ctrl) begin
      prdata[0] = run;
    end else if (sel_status) begin
      prdata[1:0]            = exec_state;
      prdata[OVF_LSB +: N_CH] = ovf_flags;
    end else if (sel_hyst) begin
      prdata[SAMPLE_W-1:0] = hyst;
    end else if (sel_thr) begin
      prdata[SAMPLE_W-1:0] = ch_cfg[idx].thresh;
    end else if (sel_off) begin
      prdata[SAMPLE_W-1:0] = ch_cfg[idx].offset;
    end
  end

endmodule

/* logic/sample_fanout.sv */
`timescale 1ns/1ns

module sample_fanout (
  input  logic                                       AXIS_ACLK,
  input  logic                                       AXIS_ARESETN,
  input  logic                                       s_tvalid,
  input  tstamp_pkg::frame_t                         s_tdata,
  input  tstamp_pkg::ch_cfg_t [tstamp_pkg::N_CH-1:0] ch_cfg,
  output logic                                       smp_valid,
  output tstamp_pkg::frame_t                         smp
);

  import tstamp_pkg::*;

  frame_t corrected;

  // offset removal, clamped at zero
  always_comb begin
    for (int i = 0; i < N_CH; i++) begin
      if (s_tdata.s[i] > ch_cfg[i].offset) begin
        corrected.s[i] = s_tdata.s[i] - ch_cfg[i].offset;
      end else begin
        corrected.s[i] = '0;
      end
    end
  end

  always_ff @(posedge AXIS_ACLK) begin
    if (!AXIS_ARESETN) begin
      smp_valid <= 1'b0;
    end else begin
      smp_valid <= s_tvalid;
    end
  end

  // sample payload only follows accepted frames
  always_ff @(posedge AXIS_ACLK) begin
    if (s_tvalid) begin
      smp <= corrected;
    end
  end

endmodule

/* logic/threshold_trigger.sv */
`timescale 1ns/1ns

module threshold_trigger #(
  parameter int CH = 0
) (
  input  logic                    AXIS_ACLK,
  input  logic                    AXIS_ARESETN,
  input  logic                    smp_valid,
  input  tstamp_pkg::sample_t     smp,
  input  tstamp_pkg::ch_cfg_t     cfg,
  input  tstamp_pkg::sample_t     hyst,
  input  tstamp_pkg::exec_state_t exec_state,
  input  tstamp_pkg::tstamp_t     current_time,
  output logic                    ev_valid,
  output tstamp_pkg::event_t      ev,
  input  logic                    ev_ready,
  output logic                    overflow
);

  import tstamp_pkg::*;

  logic    armed;
  logic    fire;
  logic    take;
  logic    load;
  sample_t rearm_lvl;

  // re-arm level, floored at zero
  assign rearm_lvl = (cfg.thresh > hyst) ? (cfg.thresh - hyst) : '0;

  assign fire = smp_valid && (exec_state != INIT) && armed && (smp > cfg.thresh);
  assign take = ev_valid && ev_ready;

  // slot is free if empty or drained this cycle
  assign load     = fire && (!ev_valid || take);
  assign overflow = fire && ev_valid && !ev_ready;

  // hysteresis state, a dropped crossing still disarms
  always_ff @(posedge AXIS_ACLK) begin
    if (!AXIS_ARESETN || exec_state == INIT) begin
      armed <= 1'b1;
    end else if (fire) begin
      armed <= 1'b0;
    end else if (smp_valid && !armed && (smp < rearm_lvl)) begin
      armed <= 1'b1;
    end
  end

  always_ff @(posedge AXIS_ACLK) begin
    if (!AXIS_ARESETN) begin
      ev_valid <= 1'b0;
    end else if (load) begin
      ev_valid <= 1'b1;
    end else if (take) begin
      ev_valid <= 1'b0;
    end
  end

  // pending event record
  always_ff @(posedge AXIS_ACLK) begin
    if (load) begin
      ev.ch     <= ch_idx_t'(CH);
      ev.sample <= smp;
      ev.ts     <= current_time;
    end
  end

endmodule

/* logic/event_merger.sv */
`timescale 1ns/1ns

module event_merger (
  input  logic                                      AXIS_ACLK,
  input  logic                                      AXIS_ARESETN,
  input  logic [tstamp_pkg::N_CH-1:0]               ev_valid,
  input  tstamp_pkg::event_t [tstamp_pkg::N_CH-1:0] ev,
  output logic [tstamp_pkg::N_CH-1:0]               ev_ready,
  output logic                                      m_tvalid,
  output tstamp_pkg::event_t                        m_tdata,
  input  logic                                      m_tready,
  output logic                                      event_taken
);

  import tstamp_pkg::*;

  ch_idx_t ptr;
  ch_idx_t grant_idx;
  logic    found;
  logic    can_load;
  logic    grant;

  // output register empty or being emptied
  assign can_load = !m_tvalid || m_tready;
  assign grant    = found && can_load;

  // first valid channel at or after the priority pointer
  always_comb begin
    ch_idx_t idx;
    found     = 1'b0;
    grant_idx = ptr;
    for (int k = 0; k < N_CH; k++) begin
      idx = ptr + ch_idx_t'(k);
      if (!found && ev_valid[idx]) begin
        found     = 1'b1;
        grant_idx = idx;
      end
    end
  end

  always_comb begin
    for (int i = 0; i < N_CH; i++) begin
      ev_ready[i] = grant && (grant_idx == ch_idx_t'(i));
    end
  end

  // pointer moves past the last winner
  always_ff @(posedge AXIS_ACLK) begin
    if (!AXIS_ARESETN) begin
      ptr         <= '0;
      m_tvalid    <= 1'b0;
      event_taken <= 1'b0;
    end else begin
      event_taken <= grant;
      if (grant) begin
        ptr      <= grant_idx + 1'b1;
        m_tvalid <= 1'b1;
      end else if (m_tready) begin
        m_tvalid <= 1'b0;
      end
    end
  end

  // holds still while stalled since no grant is made then
  always_ff @(posedge AXIS_ACLK) begin
    if (grant) begin
      m_tdata <= ev[grant_idx];
    end
  end

endmodule

/* logic/tstamp_top.sv */
`timescale 1ns/1ns

module tstamp_top (
  input  logic                  AXIS_ACLK,
  input  logic                  AXIS_ARESETN,
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  tstamp_pkg::apb_addr_t paddr,
  input  tstamp_pkg::apb_data_t pwdata,
  output tstamp_pkg::apb_data_t prdata,
  output logic                  pready,
  output logic                  pslverr,
  input  logic                  s_tvalid,
  input  tstamp_pkg::frame_t    s_tdata,
  output logic                  m_tvalid,
  output tstamp_pkg::event_t    m_tdata,
  input  logic                  m_tready
);

  import tstamp_pkg::*;

  exec_state_t              exec_state;
  tstamp_t                  current_time;
  ch_cfg_t [N_CH-1:0]       ch_cfg;
  sample_t                  hyst;
  logic                     smp_valid;
  frame_t                   smp;
  logic [N_CH-1:0]          ev_valid;
  event_t [N_CH-1:0]        ev;
  logic [N_CH-1:0]          ev_ready;
  logic [N_CH-1:0]          overflow;
  logic                     event_taken;

  apb_regs u_regs (
    .AXIS_ACLK    (AXIS_ACLK),
    .AXIS_ARESETN (AXIS_ARESETN),
    .psel         (psel),
    .penable      (penable),
    .pwrite       (pwrite),
    .paddr        (paddr),
    .pwdata       (pwdata),
    .prdata       (prdata),
    .pready       (pready),
    .pslverr      (pslverr),
    .event_taken  (event_taken),
    .overflow     (overflow),
    .exec_state   (exec_state),
    .ch_cfg       (ch_cfg),
    .hyst         (hyst)
  );

  time_counter u_time (
    .AXIS_ACLK    (AXIS_ACLK),
    .AXIS_ARESETN (AXIS_ARESETN),
    .exec_state   (exec_state),
    .current_time (current_time)
  );

  sample_fanout u_fanout (
    .AXIS_ACLK    (AXIS_ACLK),
    .AXIS_ARESETN (AXIS_ARESETN),
    .s_tvalid     (s_tvalid),
    .s_tdata      (s_tdata),
    .ch_cfg       (ch_cfg),
    .smp_valid    (smp_valid),
    .smp          (smp)
  );

  // one trigger per channel
  for (genvar i = 0; i < N_CH; i++) begin : g_ch
    threshold_trigger #(
      .CH (i)
    ) u_trig (
      .AXIS_ACLK    (AXIS_ACLK),
      .AXIS_ARESETN (AXIS_ARESETN),
      .smp_valid    (smp_valid),
      .smp          (smp.s[i]),
      .cfg          (ch_cfg[i]),
      .hyst         (hyst),
      .exec_state   (exec_state),
      .current_time (current_time),
      .ev_valid     (ev_valid[i]),
      .ev           (ev[i]),
      .ev_ready     (ev_ready[i]),
      .overflow     (overflow[i])
    );
  end

  event_merger u_merge (
    .AXIS_ACLK    (AXIS_ACLK),
    .AXIS_ARESETN (AXIS_ARESETN),
    .ev_valid     (ev_valid),
    .ev           (ev),
    .ev_ready     (ev_ready),
    .m_tvalid     (m_tvalid),
    .m_tdata      (m_tdata),
    .m_tready     (m_tready),
    .event_taken  (event_taken)
  );

endmodule

/* tb/tb_tstamp.sv */
`timescale 1ns/1ns

module tb_tstamp;

  import tstamp_pkg::*;

  // rough cycle budget of all tests together
  localparam int TEST_CYCLES = 1100;
  localparam int LIMIT       = 2 * TEST_CYCLES + 200;
  localparam int N_RAND      = 200;

  logic AXIS_ACLK = 1'b0;
  logic AXIS_ARESETN;
  logic psel, penable, pwrite, pready, pslverr;
  apb_addr_t paddr;
  apb_data_t pwdata, prdata;
  logic s_tvalid, m_tvalid;
  logic m_tready = 1'b1;
  frame_t s_tdata;
  event_t m_tdata;

  integer seed = 1826;
  int     cycles = 0;
  int     n_events = 0;
  int     rdy_mode = 0;

  // reference model state
  logic            fv;
  sample_t         fs [N_CH];
  sample_t         thr [N_CH];
  sample_t         off [N_CH];
  sample_t         hy;
  logic [N_CH-1:0] armed, pend, ovf;
  event_t          pev [N_CH];
  ch_idx_t         rr;
  logic            ov, taken_d;
  exec_state_t     st;
  int              cyc;
  event_t          exp_q [$];
  logic            stalled = 1'b0;
  event_t          held;

  tstamp_top dut (
    .AXIS_ACLK    (AXIS_ACLK),
    .AXIS_ARESETN (AXIS_ARESETN),
    .psel         (psel),
    .penable      (penable),
    .pwrite       (pwrite),
    .paddr        (paddr),
    .pwdata       (pwdata),
    .prdata       (prdata),
    .pready       (pready),
    .pslverr      (pslverr),
    .s_tvalid     (s_tvalid),
    .s_tdata      (s_tdata),
    .m_tvalid     (m_tvalid),
    .m_tdata      (m_tdata),
    .m_tready     (m_tready)
  );

  always #20 AXIS_ACLK = ~AXIS_ACLK;

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("TB FAILED");
    $fatal(1);
  endtask

  task automatic check_event(input string name, input event_t exp, input event_t act);
    string exp_s;
    string act_s;
    if (exp !== act) begin
      exp_s = $sformatf("ch=%0d smp=%0d ts=%0d", exp.ch, exp.sample, exp.ts);
      act_s = $sformatf("ch=%0d smp=%0d ts=%0d", act.ch, act.sample, act.ts);
      report_failure($sformatf("MISMATCH %s expected %s actual %s", name, exp_s, act_s));
    end
  endtask

  task automatic check_word(input string name, input apb_data_t exp, input apb_data_t act);
    if (exp !== act) begin
      report_failure($sformatf("MISMATCH %s expected 0x%08h actual 0x%08h", name, exp, act));
    end
  endtask

  task automatic check_state(input string name, input exec_state_t exp, input exec_state_t act);
    if (exp !== act) begin
      report_failure($sformatf("MISMATCH %s expected %s actual %s", name, exp.name(), act.name()));
    end
  endtask

  // offset removal clamped at zero
  function automatic sample_t correct(input sample_t raw, input sample_t o);
    return (raw > o) ? sample_t'(raw - o) : sample_t'(0);
  endfunction

  // prescaled count for c edges since leaving INIT
  function automatic tstamp_t expected_ts(input int c);
    return tstamp_t'((c - 1) / CLK_DIVIDE);
  endfunction

  // model steps on the same edges as the DUT using pre-edge values
  always @(posedge AXIS_ACLK) begin : model
    logic            wr, found;
    logic [N_CH-1:0] fire, take, pulse;
    ch_idx_t         g, idx;
    sample_t         lvl;
    if (!AXIS_ARESETN) begin
      fv = 1'b0;
      armed = '1;
      pend = '0;
      ovf = '0;
      rr = '0;
      ov = 1'b0;
      taken_d = 1'b0;
      st = INIT;
      cyc = 0;
      hy = '0;
      for (int i = 0; i < N_CH; i++) begin
        thr[i] = '0;
        off[i] = '0;
      end
    end else begin
      wr = psel && penable && pwrite;
      found = 1'b0;
      g = rr;
      if (!ov || m_tready) begin
        for (int k = 0; k < N_CH; k++) begin
          idx = rr + ch_idx_t'(k);
          if (!found && pend[idx]) begin
            found = 1'b1;
            g = idx;
          end
        end
      end
      take = '0;
      pulse = '0;
      if (found) begin
        take[g] = 1'b1;
        exp_q.push_back(pev[g]);
        rr = g + 1'b1;
        ov = 1'b1;
      end else if (m_tready) begin
        ov = 1'b0;
      end
      for (int i = 0; i < N_CH; i++) begin
        fire[i] = fv && (st != INIT) && armed[i] && (fs[i] > thr[i]);
        lvl = (thr[i] > hy) ? sample_t'(thr[i] - hy) : sample_t'(0);
        if (fire[i] && pend[i] && !take[i]) begin
          pulse[i] = 1'b1;
        end
        if (fire[i] && (!pend[i] || take[i])) begin
          pend[i] = 1'b1;
          pev[i] = '{ch: ch_idx_t'(i), sample: fs[i], ts: expected_ts(cyc)};
        end else if (take[i]) begin
          pend[i] = 1'b0;
        end
        if (st == INIT) armed[i] = 1'b1;
        else if (fire[i]) armed[i] = 1'b0;
        else if (fv && !armed[i] && (fs[i] < lvl)) armed[i] = 1'b1;
      end
      if (wr && paddr == 8'h04) ovf = ovf & ~pwdata[7:4];
      ovf = ovf | pulse;
      fv = s_tvalid;
      if (s_tvalid) begin
        for (int i = 0; i < N_CH; i++) fs[i] = correct(s_tdata.s[i], off[i]);
      end
      if (wr && paddr == 8'h00 && !pwdata[0]) st = INIT;
      else if (st == INIT && wr && paddr == 8'h00) st = ARMED;
      else if (st == ARMED && taken_d) st = TRG;
      taken_d = found;
      cyc = (st == INIT) ? 0 : cyc + 1;
      if (wr && paddr == 8'h08) hy = pwdata[SAMPLE_W-1:0];
      if (wr && paddr[7:4] == 4'h1 && paddr[1:0] == 2'b00) thr[paddr[3:2]] = pwdata[SAMPLE_W-1:0];
      if (wr && paddr[7:4] == 4'h2 && paddr[1:0] == 2'b00) off[paddr[3:2]] = pwdata[SAMPLE_W-1:0];
    end
  end

  // compare every output handshake and hold stability while stalled
  always @(posedge AXIS_ACLK) begin
    if (AXIS_ARESETN) begin
      if (stalled) check_event("stall_stable", held, m_tdata);
      if (m_tvalid && m_tready) begin
        if (exp_q.size() == 0) report_failure("output event appeared with none expected");
        else check_event("output_event", exp_q.pop_front(), m_tdata);
        n_events++;
      end
      stalled = m_tvalid && !m_tready;
      held = m_tdata;
    end
  end

  always @(posedge AXIS_ACLK) begin
    cycles <= cycles + 1;
    if (cycles >= LIMIT) report_failure("run hung, cycle limit reached");
  end

  // 0 always ready, 1 random, 2 held low
  always @(posedge AXIS_ACLK) begin
    if (rdy_mode == 0) m_tready <= 1'b1;
    else if (rdy_mode == 1) m_tready <= 1'($random(seed));
    else m_tready <= 1'b0;
  end

  task automatic apb_write(input apb_addr_t a, input apb_data_t d);
    @(posedge AXIS_ACLK);
    psel <= 1'b1;
    penable <= 1'b0;
    pwrite <= 1'b1;
    paddr <= a;
    pwdata <= d;
    @(posedge AXIS_ACLK);
    penable <= 1'b1;
    @(posedge AXIS_ACLK);
    psel <= 1'b0;
    penable <= 1'b0;
    pwrite <= 1'b0;
  endtask

  task automatic apb_read(input apb_addr_t a, output apb_data_t d, output logic err);
    @(posedge AXIS_ACLK);
    psel <= 1'b1;
    penable <= 1'b0;
    pwrite <= 1'b0;
    paddr <= a;
    @(posedge AXIS_ACLK);
    penable <= 1'b1;
    @(negedge AXIS_ACLK);
    d = prdata;
    err = pslverr;
    check_word("pready", 32'd1, {31'b0, pready});
    @(posedge AXIS_ACLK);
    psel <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic read_status(input string name, input exec_state_t exp_st);
    apb_data_t d;
    logic      e;
    apb_read(8'h04, d, e);
    check_state(name, exp_st, exec_state_t'(d[1:0]));
    check_word(name, {24'b0, ovf, 2'b00, exp_st}, d);
  endtask

  function automatic frame_t all_ch(input sample_t v);
    frame_t f;
    for (int i = 0; i < N_CH; i++) f.s[i] = v;
    return f;
  endfunction

  task automatic send_frame(input frame_t f);
    @(posedge AXIS_ACLK);
    s_tvalid <= 1'b1;
    s_tdata <= f;
  endtask

  task automatic idle();
    @(posedge AXIS_ACLK);
    s_tvalid <= 1'b0;
  endtask

  // up then down below the re-arm level then up again
  task automatic ramp();
    for (int v = 0; v <= 2000; v += 100) send_frame(all_ch(sample_t'(v)));
    for (int v = 2000; v >= 0; v -= 250) send_frame(all_ch(sample_t'(v)));
    for (int v = 0; v <= 2000; v += 200) send_frame(all_ch(sample_t'(v)));
    idle();
  endtask

  task automatic drain();
    rdy_mode <= 0;
    repeat (3) @(posedge AXIS_ACLK);
    @(negedge AXIS_ACLK);
    while (exp_q.size() != 0 || pend != '0 || m_tvalid || ov) @(negedge AXIS_ACLK);
  endtask

  initial begin
    apb_data_t d;
    logic      e;
    int        seen;
    frame_t    rnd_frames [N_RAND];
    AXIS_ARESETN = 1'b0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    s_tvalid = 1'b0;
    s_tdata = '0;
    repeat (10) @(posedge AXIS_ACLK);
    AXIS_ARESETN <= 1'b1;
    // register access and reset values
    read_status("status_reset", INIT);
    check_word("m_tvalid_reset", 32'd0, {31'b0, m_tvalid});
    apb_write(8'h08, 32'd200);
    for (int i = 0; i < N_CH; i++) begin
      apb_write(apb_addr_t'(8'h10 + 4 * i), 32'd1000);
      apb_write(apb_addr_t'(8'h20 + 4 * i), apb_data_t'(100 * i));
    end
    apb_read(8'h08, d, e);
    check_word("hyst_rb", 32'd200, d);
    for (int i = 0; i < N_CH; i++) begin
      apb_read(apb_addr_t'(8'h10 + 4 * i), d, e);
      check_word("thresh_rb", 32'd1000, d);
      apb_read(apb_addr_t'(8'h20 + 4 * i), d, e);
      check_word("offset_rb", apb_data_t'(100 * i), d);
    end
    apb_read(8'h40, d, e);
    check_word("unmapped_pslverr", 32'd1, {31'b0, e});
    // arm then trigger with hysteresis
    apb_write(8'h00, 32'd1);
    read_status("status_armed", ARMED);
    ramp();
    drain();
    read_status("status_trg", TRG);
    // stop with no events then run again with a fresh count
    apb_write(8'h00, 32'd0);
    read_status("status_init", INIT);
    seen = n_events;
    ramp();
    drain();
    check_word("no_events_in_init", apb_data_t'(seen), apb_data_t'(n_events));
    apb_write(8'h00, 32'd1);
    ramp();
    drain();
    // random frames under random back-pressure
    for (int n = 0; n < N_RAND; n++) begin
      for (int i = 0; i < N_CH; i++) rnd_frames[n].s[i] = sample_t'($random(seed));
    end
    rdy_mode <= 1;
    for (int n = 0; n < N_RAND; n++) send_frame(rnd_frames[n]);
    idle();
    drain();
    read_status("status_random", TRG);
    // overflow on channel 0 with the output stalled
    apb_write(8'h04, 32'hF0);
    send_frame(all_ch(12'd0));
    rdy_mode <= 2;
    for (int n = 0; n < 3; n++) begin
      send_frame('{s: '{12'd0, 12'd0, 12'd0, 12'd2000}});
      send_frame(all_ch(12'd0));
    end
    idle();
    repeat (4) @(posedge AXIS_ACLK);
    apb_read(8'h04, d, e);
    check_word("ovf_set", 32'd1, (d >> 4) & 32'd1);
    read_status("status_ovf", TRG);
    apb_write(8'h04, 32'h10);
    apb_read(8'h04, d, e);
    check_word("ovf_cleared", 32'd0, (d >> 4) & 32'd1);
    drain();
    if (n_events == 0) report_failure("no output events were seen");
    $display("TB PASSED");
    $finish;
  end

endmodule

/* all.f */
common/tstamp_pkg.sv
logic/time_counter.sv
logic/apb_regs.sv
logic/sample_fanout.sv
logic/threshold_trigger.sv
logic/event_merger.sv
logic/tstamp_top.sv
tb/tb_tstamp.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f all.f --top-module tb_tstamp -o tb_sim
./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "TB PASSED" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
